//--- pipe_ctrl.f
hdl/rv_ctrl_pkg.sv
hdl/decode_ctrl.sv
hdl/alu_decode.sv
hdl/exec_ctrl.sv
hdl/wb_ctrl.sv
hdl/pipe_ctrl.sv
verif/pipe_ctrl_tb.sv

//--- Bender.yml
package:
  name: pipe_ctrl

sources:
  - hdl/rv_ctrl_pkg.sv
  - hdl/decode_ctrl.sv
  - hdl/alu_decode.sv
  - hdl/exec_ctrl.sv
  - hdl/wb_ctrl.sv
  - hdl/pipe_ctrl.sv
  - target: simulation
    files:
      - verif/pipe_ctrl_tb.sv

//--- verif/pipe_ctrl_tb.sv
`timescale 1ns/1ps

module pipe_ctrl_tb;
  import rv_ctrl_pkg::*;

  // Full 7-bit major opcodes
  localparam logic [6:0] OP_R     = 7'h33;
  localparam logic [6:0] OP_I     = 7'h13;
  localparam logic [6:0] OP_LD    = 7'h03;
  localparam logic [6:0] OP_ST    = 7'h23;
  localparam logic [6:0] OP_BR    = 7'h63;
  localparam logic [6:0] OP_JAL   = 7'h6f;
  localparam logic [6:0] OP_JALR  = 7'h67;
  localparam logic [6:0] OP_AUIPC = 7'h17;
  localparam logic [6:0] OP_LUI   = 7'h37;
  localparam logic [6:0] FILLER_OPS [9] = '{OP_R, OP_I, OP_LD, OP_ST, OP_BR, OP_JAL,
                                            OP_JALR, OP_AUIPC, OP_LUI};
  localparam alu_op_e F3_OPS [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                                     ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};

  typedef struct packed {
    inst_t    inst;
    logic     eq;
    logic     lt;
    d_ctrl_t  d;
    x_ctrl_t  x;
    wb_ctrl_t wb;
    pc_sel_e  pc;
  } row_t;

  logic     clk = 1'b0;
  logic     rst;
  inst_t    inst;
  logic     br_eq;
  logic     br_lt;
  d_ctrl_t  d_ctrl;
  x_ctrl_t  x_ctrl;
  wb_ctrl_t wb_ctrl;
  pc_sel_e  pc_sel;

  row_t        table_q[$];
  inst_t       model_x = NOP_INST; // Expected X and WF contents
  inst_t       model_wf = NOP_INST;
  logic [31:0] lcg_state = 32'd8;
  logic        table_ready = 1'b0;

  always #50 clk = ~clk;

  pipe_ctrl dut0 (
    .clk     (clk),
    .rst     (rst),
    .inst    (inst),
    .br_eq   (br_eq),
    .br_lt   (br_lt),
    .d_ctrl  (d_ctrl),
    .x_ctrl  (x_ctrl),
    .wb_ctrl (wb_ctrl),
    .pc_sel  (pc_sel)
  );

  function automatic inst_t encode(input logic [6:0] f7, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3,
                                   input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16; // Upper bits only
  endfunction

  function automatic logic writes_reg(input inst_t i);
    return i[6:0] != OP_ST && i[6:0] != OP_BR && i[11:7] != 5'd0;
  endfunction

  function automatic d_ctrl_t d_bypass(input inst_t d, input inst_t wf);
    d_ctrl_t c;
    c.fwd_rs1 = writes_reg(wf) && wf[11:7] == d[19:15];
    c.fwd_rs2 = writes_reg(wf) && wf[11:7] == d[24:20];
    return c;
  endfunction

  function automatic x_ctrl_t x_decode(input inst_t x, input inst_t wf,
                                       input logic eq, input logic lt);
    x_ctrl_t  c;
    fwd_sel_e src;
    logic     hit_a;
    logic     hit_b;
    src   = (wf[6:0] == OP_LD) ? FWD_MEM : FWD_ALU;
    hit_a = writes_reg(wf) && wf[11:7] == x[19:15];
    hit_b = writes_reg(wf) && wf[11:7] == x[24:20];
    c.alu_op = ALU_ADD;
    if (x[6:0] == OP_R || x[6:0] == OP_I) begin
      c.alu_op = F3_OPS[x[14:12]];
      if (x[14:12] == 3'd0 && x[6:0] == OP_R && x[30]) begin
        c.alu_op = ALU_SUB;
      end else if (x[14:12] == 3'd5 && x[30]) begin
        c.alu_op = ALU_SRA;
      end
    end else if (x[6:0] == OP_LUI) begin
      c.alu_op = ALU_PASS_B;
    end
    c.b_imm = x[6:0] != OP_R;
    c.br_un = x[6:0] == OP_BR && x[13]; // bltu and bgeu
    if (x[6:0] == OP_BR || x[6:0] == OP_JAL || x[6:0] == OP_AUIPC) begin
      c.a_sel = A_PC;
    end else if (x[6:0] == OP_ST && wf[6:0] == OP_LD && hit_a) begin
      c.a_sel = A_MEM;
    end else begin
      c.a_sel = A_RS1;
    end
    c.fwd_a     = hit_a ? src : FWD_RF;
    c.fwd_b     = hit_b ? src : FWD_RF;
    c.store_fwd = (x[6:0] == OP_ST && hit_b) ? src : FWD_RF;
    c.br_taken  = 1'b0;
    if (x[6:0] == OP_BR) begin
      case (x[14:12])
        3'd0:       c.br_taken = eq;
        3'd1:       c.br_taken = !eq;
        3'd4, 3'd6: c.br_taken = lt;
        3'd5, 3'd7: c.br_taken = !lt || eq;
        default:    c.br_taken = 1'b0;
      endcase
    end
    return c;
  endfunction

  function automatic wb_ctrl_t wb_decode(input inst_t wf);
    wb_ctrl_t c;
    c.rf_we   = (wf[6:0] inside {OP_R, OP_I, OP_LD, OP_JAL, OP_JALR, OP_AUIPC, OP_LUI}) &&
                wf[11:7] != 5'd0;
    c.wb_sel  = WB_ALU;
    c.ldx_sel = LDX_W;
    if (wf[6:0] == OP_LD) begin
      c.wb_sel = WB_MEM;
      case (wf[14:12])
        3'd0:    c.ldx_sel = LDX_BS;
        3'd1:    c.ldx_sel = LDX_HS;
        3'd4:    c.ldx_sel = LDX_BU;
        3'd5:    c.ldx_sel = LDX_HU;
        default: c.ldx_sel = LDX_W;
      endcase
    end else if (wf[6:0] == OP_JAL || wf[6:0] == OP_JALR) begin
      c.wb_sel = WB_PC4;
    end
    return c;
  endfunction

  // Expected values for the cycle this row is driven, then the model advances
  task automatic add_row(input inst_t i, input logic eq, input logic lt);
    row_t r;
    logic redirect;
    r.inst   = i;
    r.eq     = eq;
    r.lt     = lt;
    r.d      = d_bypass(i, model_wf);
    r.x      = x_decode(model_x, model_wf, eq, lt);
    r.wb     = wb_decode(model_wf);
    redirect = r.x.br_taken || model_x[6:0] == OP_JALR;
    if (redirect) begin
      r.pc = PC_ALU;
    end else if (i[6:0] == OP_JAL) begin
      r.pc = PC_JAL;
    end else begin
      r.pc = PC_PLUS4;
    end
    table_q.push_back(r);
    model_wf = model_x;
    model_x  = redirect ? NOP_INST : i;
  endtask

  task automatic build_table();
    logic [31:0] r;
    logic [6:0]  op;
    logic [2:0]  f3;
    int          f;
    int          c;
    int          n;
    add_row(encode(7'h00, 5'd3, 5'd2, 3'd0, 5'd1, OP_R), 1'b0, 1'b0);    // add
    add_row(encode(7'h20, 5'd6, 5'd5, 3'd0, 5'd4, OP_R), 1'b0, 1'b0);    // sub
    add_row(encode(7'h20, 5'd9, 5'd8, 3'd5, 5'd7, OP_R), 1'b0, 1'b0);    // sra
    add_row(encode(7'h00, 5'd12, 5'd11, 3'd3, 5'd10, OP_R), 1'b0, 1'b0); // sltu
    add_row(encode(7'h20, 5'd3, 5'd14, 3'd5, 5'd13, OP_I), 1'b0, 1'b0);  // srai
    add_row(encode(7'h20, 5'd1, 5'd16, 3'd0, 5'd15, OP_I), 1'b0, 1'b0);  // addi with bit 30 set
    add_row(encode(7'h00, 5'd7, 5'd17, 3'd3, 5'd18, OP_I), 1'b0, 1'b0);  // sltiu
    add_row(encode(7'h12, 5'd5, 5'd3, 3'd1, 5'd19, OP_LUI), 1'b0, 1'b0); // lui
    add_row(encode(7'h00, 5'd0, 5'd1, 3'd0, 5'd5, OP_I), 1'b0, 1'b0);    // addi x5
    add_row(encode(7'h00, 5'd5, 5'd5, 3'd0, 5'd6, OP_R), 1'b0, 1'b0);    // ALU forward both
    add_row(encode(7'h00, 5'd0, 5'd2, 3'd2, 5'd7, OP_LD), 1'b0, 1'b0);   // lw x7
    add_row(encode(7'h00, 5'd7, 5'd7, 3'd2, 5'd0, OP_ST), 1'b0, 1'b0);   // sw x7,0(x7)
    add_row(encode(7'h00, 5'd0, 5'd3, 3'd0, 5'd0, OP_I), 1'b0, 1'b0);    // addi x0
    add_row(encode(7'h00, 5'd0, 5'd0, 3'd0, 5'd8, OP_R), 1'b0, 1'b0);    // Reads x0
    add_row(encode(7'h00, 5'd0, 5'd1, 3'd2, 5'd9, OP_LD), 1'b0, 1'b0);   // lw x9
    add_row(encode(7'h00, 5'd9, 5'd2, 3'd2, 5'd4, OP_ST), 1'b0, 1'b0);   // Store data from load
    add_row(encode(7'h00, 5'd1, 5'd0, 3'd0, 5'd11, OP_I), 1'b0, 1'b0);   // addi x11
    add_row(encode(7'h00, 5'd2, 5'd0, 3'd0, 5'd12, OP_I), 1'b0, 1'b0);   // addi x12
    add_row(encode(7'h00, 5'd11, 5'd11, 3'd0, 5'd13, OP_R), 1'b0, 1'b0); // D bypass on both ports
    add_row(encode(7'h00, 5'd0, 5'd1, 3'd0, 5'd20, OP_LD), 1'b0, 1'b0);  // lb
    add_row(encode(7'h00, 5'd0, 5'd1, 3'd1, 5'd21, OP_LD), 1'b0, 1'b0);  // lh
    add_row(encode(7'h00, 5'd0, 5'd1, 3'd2, 5'd22, OP_LD), 1'b0, 1'b0);  // lw
    add_row(encode(7'h00, 5'd0, 5'd1, 3'd4, 5'd23, OP_LD), 1'b0, 1'b0);  // lbu
    add_row(encode(7'h00, 5'd0, 5'd1, 3'd5, 5'd24, OP_LD), 1'b0, 1'b0);  // lhu
    add_row(encode(7'h00, 5'd4, 5'd1, 3'd2, 5'd8, OP_ST), 1'b0, 1'b0);   // sw
    add_row(encode(7'h00, 5'd4, 5'd1, 3'd1, 5'd8, OP_BR), 1'b0, 1'b0);   // bne
    add_row(encode(7'h00, 5'd0, 5'd0, 3'd0, 5'd1, OP_JAL), 1'b1, 1'b0);  // jal x1 while bne falls through
    add_row(encode(7'h00, 5'd0, 5'd5, 3'd0, 5'd1, OP_JALR), 1'b0, 1'b0); // jalr x1
    add_row(encode(7'h00, 5'd0, 5'd0, 3'd0, 5'd6, OP_I), 1'b0, 1'b0);    // Squashed by jalr
    add_row(encode(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, OP_JAL), 1'b0, 1'b0);  // jal x0
    // Every branch funct3 against every flag pair with a sub behind that dies when taken
    for (f = 0; f < 8; f++) begin
      if (f != 2 && f != 3) begin
        for (c = 0; c < 4; c++) begin
          add_row(encode(7'h00, 5'd2, 5'd1, 3'(f), 5'd0, OP_BR), 1'b0, 1'b0);
          add_row(encode(7'h20, 5'd2, 5'd1, 3'd0, 5'd3, OP_R), c[1], c[0]);
        end
      end
    end
    for (n = 0; n < 40; n++) begin
      r  = next_rand();
      op = FILLER_OPS[next_rand() % 9];
      f3 = r[12:10];
      if (op == OP_BR && f3[2:1] == 2'b01) begin
        f3[2] = 1'b1; // No branch uses funct3 2 or 3
      end
      add_row(encode({1'b0, r[0], 5'd0}, {2'b00, r[9:7]}, {2'b00, r[6:4]}, f3,
                     {2'b00, r[3:1]}, op), r[13], r[14]);
    end
  endtask

  task automatic stop_on_failure();
    $display("TEST FAIL");
    $fatal(1, "Stopped at the first failing check");
  endtask

  task automatic check_d(input d_ctrl_t got, input d_ctrl_t exp, input int row);
    if (got !== exp) begin
      $display("Error: d_ctrl row %0d got %h expected %h", row, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_x(input x_ctrl_t got, input x_ctrl_t exp, input int row);
    if (got !== exp) begin
      $display("Error: x_ctrl row %0d got %h expected %h", row, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_wb(input wb_ctrl_t got, input wb_ctrl_t exp, input int row);
    if (got !== exp) begin
      $display("Error: wb_ctrl row %0d got %h expected %h", row, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_pc(input pc_sel_e got, input pc_sel_e exp, input int row);
    if (got !== exp) begin
      $display("Error: pc_sel row %0d got %h expected %h", row, got, exp);
      stop_on_failure();
    end
  endtask

  initial begin
    rst   = 1'b1;
    inst  = NOP_INST;
    br_eq = 1'b0;
    br_lt = 1'b0;
    build_table();
    table_ready = 1'b1;
    #1;
    repeat (10) begin
      #40;
      check_pc(pc_sel, PC_RESET, -1); // Row -1 marks the reset phase
      @(posedge clk);
      #1;
    end
    rst = 1'b0;
    for (int n = 0; n < table_q.size(); n++) begin
      inst  = table_q[n].inst;
      br_eq = table_q[n].eq;
      br_lt = table_q[n].lt;
      #40;
      check_d(d_ctrl, table_q[n].d, n);
      check_x(x_ctrl, table_q[n].x, n);
      check_wb(wb_ctrl, table_q[n].wb, n);
      check_pc(pc_sel, table_q[n].pc, n);
      @(posedge clk);
      #1;
    end
    $display("TEST PASS");
    $finish;
  end

  initial begin
    wait (table_ready);
    #((table_q.size() + 20) * 100);
    $display("Timeout: the table was not finished in the expected time");
    stop_on_failure();
  end

endmodule

//--- hdl/pipe_ctrl.sv
`timescale 1ns/1ps

module pipe_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_ctrl_pkg::inst_t    inst,
  input  logic                  br_eq,
  input  logic                  br_lt,
  output rv_ctrl_pkg::d_ctrl_t  d_ctrl,
  output rv_ctrl_pkg::x_ctrl_t  x_ctrl,
  output rv_ctrl_pkg::wb_ctrl_t wb_ctrl,
  output rv_ctrl_pkg::pc_sel_e  pc_sel
);
  import rv_ctrl_pkg::*;

  inst_t x_inst;
  inst_t wf_inst;
  logic  redirect;

  always_ff @(posedge clk) begin
    if (rst) begin
      x_inst  <= NOP_INST;
      wf_inst <= NOP_INST;
    end else begin
      x_inst  <= redirect ? NOP_INST : inst; // Squash the wrong-path fetch
      wf_inst <= x_inst;
    end
  end

  decode_ctrl u_decode_ctrl (
    .rst      (rst),
    .inst     (inst),
    .wf_inst  (wf_inst),
    .redirect (redirect),
    .d_ctrl   (d_ctrl),
    .pc_sel   (pc_sel)
  );

  exec_ctrl u_exec_ctrl (
    .x_inst   (x_inst),
    .wf_inst  (wf_inst),
    .br_eq    (br_eq),
    .br_lt    (br_lt),
    .x_ctrl   (x_ctrl),
    .redirect (redirect)
  );

  wb_ctrl u_wb_ctrl (
    .wf_inst (wf_inst),
    .wb_ctrl (wb_ctrl)
  );

  // A redirect in X must leave a bubble behind it
  a_flush: assert property (@(posedge clk) disable iff (rst)
    redirect |=> (x_inst == NOP_INST))
    else $error("x_inst not flushed after redirect");

endmodule

//--- hdl/wb_ctrl.sv
`timescale 1ns/1ps

module wb_ctrl (
  input  rv_ctrl_pkg::inst_t    wf_inst,
  output rv_ctrl_pkg::wb_ctrl_t wb_ctrl
);
  import rv_ctrl_pkg::*;

  logic    we;
  wb_sel_e src;
  ldx_e    ldx;

  always_comb begin
    we  = 1'b0;
    src = WB_ALU;
    ldx = LDX_W;
    case (opc_of(wf_inst))
      OPC_ARI_R, OPC_ARI_I, OPC_AUIPC, OPC_LUI: begin
        we = 1'b1;
      end
      OPC_LOAD: begin
        we  = 1'b1;
        src = WB_MEM;
        case (load_fn_e'(f3_of(wf_inst)))
          F3_LB:   ldx = LDX_BS;
          F3_LH:   ldx = LDX_HS;
          F3_LBU:  ldx = LDX_BU;
          F3_LHU:  ldx = LDX_HU;
          default: ldx = LDX_W;
        endcase
      end
      OPC_JAL, OPC_JALR: begin
        we  = 1'b1;
        src = WB_PC4; // Link address
      end
      default: begin
        we = 1'b0; // Store, branch, unknown
      end
    endcase
  end

  always_comb begin
    wb_ctrl.rf_we   = we && (rd_of(wf_inst) != 5'd0);
    wb_ctrl.wb_sel  = src;
    wb_ctrl.ldx_sel = ldx;
  end

endmodule

//--- hdl/exec_ctrl.sv
`timescale 1ns/1ps

module exec_ctrl (
  input  rv_ctrl_pkg::inst_t   x_inst,
  input  rv_ctrl_pkg::inst_t   wf_inst,
  input  logic                 br_eq,
  input  logic                 br_lt,
  output rv_ctrl_pkg::x_ctrl_t x_ctrl,
  output logic                 redirect
);
  import rv_ctrl_pkg::*;

  opcode_e    x_opc;
  opcode_e    wf_opc;
  logic [4:0] wf_rd;
  logic       wf_wr;
  fwd_sel_e   wf_src;
  alu_op_e    alu_op;
  logic       b_imm;
  logic       br_un;
  fwd_sel_e   fwd_a;
  fwd_sel_e   fwd_b;
  fwd_sel_e   store_fwd;
  a_sel_e     a_sel;
  logic       br_taken;

  assign x_opc  = opc_of(x_inst);
  assign wf_opc = opc_of(wf_inst);
  assign wf_rd  = rd_of(wf_inst);
  assign wf_wr  = writes_rd(wf_inst);
  assign wf_src = (wf_opc == OPC_LOAD) ? FWD_MEM : FWD_ALU; // Load data or ALU result

  alu_decode u_alu_decode (
    .x_inst (x_inst),
    .alu_op (alu_op),
    .b_imm  (b_imm),
    .br_un  (br_un)
  );

  always_comb begin
    fwd_a     = (wf_wr && wf_rd == rs1_of(x_inst)) ? wf_src : FWD_RF;
    fwd_b     = (wf_wr && wf_rd == rs2_of(x_inst)) ? wf_src : FWD_RF;
    store_fwd = FWD_RF;
    if (x_opc == OPC_STORE && wf_wr && wf_rd == rs2_of(x_inst)) begin
      store_fwd = wf_src; // Store data produced one ahead
    end
  end

  always_comb begin
    if (x_opc == OPC_BRANCH || x_opc == OPC_JAL || x_opc == OPC_AUIPC) begin
      a_sel = A_PC;
    end else if (x_opc == OPC_STORE && wf_opc == OPC_LOAD && wf_wr &&
                 wf_rd == rs1_of(x_inst)) begin
      a_sel = A_MEM; // Base address from the load in WF
    end else begin
      a_sel = A_RS1;
    end
  end

  always_comb begin
    br_taken = 1'b0;
    if (x_opc == OPC_BRANCH) begin
      case (f3_of(x_inst))
        F3_BEQ:           br_taken = br_eq;
        F3_BNE:           br_taken = !br_eq;
        F3_BLT, F3_BLTU:  br_taken = br_lt;
        F3_BGE, F3_BGEU:  br_taken = !br_lt || br_eq;
        default:          br_taken = 1'b0;
      endcase
    end
  end

  assign redirect = br_taken || (x_opc == OPC_JALR);

  always_comb begin
    x_ctrl.alu_op    = alu_op;
    x_ctrl.b_imm     = b_imm;
    x_ctrl.br_un     = br_un;
    x_ctrl.a_sel     = a_sel;
    x_ctrl.fwd_a     = fwd_a;
    x_ctrl.fwd_b     = fwd_b;
    x_ctrl.store_fwd = store_fwd;
    x_ctrl.br_taken  = br_taken;
  end

  always_comb begin
    if (wf_rd == 5'd0) begin
      a_no_fwd_x0: assert final (fwd_a == FWD_RF && fwd_b == FWD_RF &&
                                 store_fwd == FWD_RF && a_sel != A_MEM)
        else $error("forward select active for x0 in WF");
    end
  end

endmodule

//--- hdl/alu_decode.sv
`timescale 1ns/1ps

module alu_decode (
  input  rv_ctrl_pkg::inst_t   x_inst,
  output rv_ctrl_pkg::alu_op_e alu_op,
  output logic                 b_imm,
  output logic                 br_un
);
  import rv_ctrl_pkg::*;

  // funct3 to operation for both R-type and I-type
  function automatic alu_op_e arith_op(
    input logic [2:0] f3,
    input logic       alt,
    input logic       r_type
  );
    case (f3)
      3'b000:  return (alt && r_type) ? ALU_SUB : ALU_ADD; // No subi
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  logic [2:0] f3;
  logic       alt;

  assign f3  = f3_of(x_inst);
  assign alt = x_inst[30]; // Picks sub and sra

  always_comb begin
    alu_op = ALU_ADD; // Address and PC arithmetic
    b_imm  = 1'b1;
    br_un  = 1'b0;
    case (opc_of(x_inst))
      OPC_ARI_R: begin
        alu_op = arith_op(f3, alt, 1'b1);
        b_imm  = 1'b0;
      end
      OPC_ARI_I: begin
        alu_op = arith_op(f3, alt, 1'b0);
      end
      OPC_LUI: begin
        alu_op = ALU_PASS_B;
      end
      OPC_BRANCH: begin
        br_un = (f3 == F3_BLTU) || (f3 == F3_BGEU);
      end
      default: begin
        alu_op = ALU_ADD;
      end
    endcase
  end

endmodule

//--- hdl/decode_ctrl.sv
`timescale 1ns/1ps

module decode_ctrl (
  input  logic                 rst,
  input  rv_ctrl_pkg::inst_t   inst,
  input  rv_ctrl_pkg::inst_t   wf_inst,
  input  logic                 redirect,
  output rv_ctrl_pkg::d_ctrl_t d_ctrl,
  output rv_ctrl_pkg::pc_sel_e pc_sel
);
  import rv_ctrl_pkg::*;

  logic       wf_wr;
  logic [4:0] wf_rd;

  assign wf_wr = writes_rd(wf_inst);
  assign wf_rd = rd_of(wf_inst);

  // Two-cycle hazard where WF writes back while D reads the file
  always_comb begin
    d_ctrl.fwd_rs1 = wf_wr && (wf_rd == rs1_of(inst));
    d_ctrl.fwd_rs2 = wf_wr && (wf_rd == rs2_of(inst));
  end

  always_comb begin
    if (rst) begin
      pc_sel = PC_RESET;
    end else if (redirect) begin
      pc_sel = PC_ALU; // Taken branch or jalr in X
    end else if (opc_of(inst) == OPC_JAL) begin
      pc_sel = PC_JAL;
    end else begin
      pc_sel = PC_PLUS4;
    end
  end

  always_comb begin
    if (!rst) begin
      a_no_reset_pc: assert final (pc_sel != PC_RESET)
        else $error("pc_sel selects reset vector outside reset");
    end
  end

endmodule

//--- hdl/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

  typedef logic [31:0] inst_t;

  localparam inst_t NOP_INST = 32'h0000_0013; // addi x0, x0, 0

  // Major opcode, instruction bits 6:2
  typedef enum logic [4:0] {
    OPC_LOAD   = 5'b00000,
    OPC_ARI_I  = 5'b00100,
    OPC_AUIPC  = 5'b00101,
    OPC_STORE  = 5'b01000,
    OPC_ARI_R  = 5'b01100,
    OPC_LUI    = 5'b01101,
    OPC_BRANCH = 5'b11000,
    OPC_JALR   = 5'b11001,
    OPC_JAL    = 5'b11011
  } opcode_e;

  typedef enum logic [2:0] {
    F3_BEQ  = 3'b000,
    F3_BNE  = 3'b001,
    F3_BLT  = 3'b100,
    F3_BGE  = 3'b101,
    F3_BLTU = 3'b110,
    F3_BGEU = 3'b111
  } branch_fn_e;

  typedef enum logic [2:0] {
    F3_LB  = 3'b000,
    F3_LH  = 3'b001,
    F3_LW  = 3'b010,
    F3_LBU = 3'b100,
    F3_LHU = 3'b101
  } load_fn_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
    ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {FWD_RF, FWD_ALU, FWD_MEM} fwd_sel_e;

  typedef enum logic [1:0] {A_RS1, A_PC, A_MEM} a_sel_e;

  typedef enum logic [1:0] {WB_MEM, WB_ALU, WB_PC4} wb_sel_e;

  typedef enum logic [2:0] {LDX_W, LDX_HU, LDX_HS, LDX_BU, LDX_BS} ldx_e;

  typedef enum logic [1:0] {PC_RESET, PC_JAL, PC_PLUS4, PC_ALU} pc_sel_e;

  typedef struct packed {
    logic fwd_rs1; // Read port 1 bypass from WF
    logic fwd_rs2; // Read port 2 bypass from WF
  } d_ctrl_t;

  typedef struct packed {
    alu_op_e  alu_op;
    logic     b_imm;     // B operand is the immediate
    logic     br_un;     // Unsigned compare
    a_sel_e   a_sel;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    fwd_sel_e store_fwd; // Store data source
    logic     br_taken;
  } x_ctrl_t;

  typedef struct packed {
    logic    rf_we;
    wb_sel_e wb_sel;
    ldx_e    ldx_sel;
  } wb_ctrl_t;

  function automatic logic [4:0] rd_of(input inst_t i);
    return i[11:7];
  endfunction

  function automatic logic [4:0] rs1_of(input inst_t i);
    return i[19:15];
  endfunction

  function automatic logic [4:0] rs2_of(input inst_t i);
    return i[24:20];
  endfunction

  function automatic opcode_e opc_of(input inst_t i);
    return opcode_e'(i[6:2]);
  endfunction

  function automatic logic [2:0] f3_of(input inst_t i);
    return i[14:12];
  endfunction

  // True when the instruction produces a register result worth bypassing
  function automatic logic writes_rd(input inst_t i);
    return (opc_of(i) != OPC_STORE) && (opc_of(i) != OPC_BRANCH) && (rd_of(i) != 5'd0);
  endfunction

endpackage
